//--- asm_loader.f
asm_loader_pkg.sv
uart_rx.sv
word_packer.sv
word_store.sv
seg_display.sv
asm_loader_top.sv
tb_asm_loader.sv

//--- asm_loader_pkg.sv
package asm_loader_pkg;

   // uart timing, shortened for simulation
   localparam int clks_per_bit = 16;
   localparam int clk_cnt_w = $clog2(clks_per_bit);
   localparam logic [clk_cnt_w-1:0] half_bit_cnt = clk_cnt_w'(clks_per_bit / 2 - 1);
   localparam logic [clk_cnt_w-1:0] full_bit_cnt = clk_cnt_w'(clks_per_bit - 1);

   localparam int byte_w = 8;
   localparam int bit_idx_w = $clog2(byte_w);

   localparam int word_bytes = 16;
   localparam int byte_idx_w = $clog2(word_bytes);
   localparam int word_w = 128;
   localparam int chunk_w = 32;
   localparam int chunk_sel_w = 2;

   localparam int mem_addr_w = 6;
   localparam int mem_words = 2 ** mem_addr_w;
   localparam int count_w = 8;

   // display scan
   localparam int digit_count = 8;
   localparam int digit_cycles = 8;
   localparam int digit_sel_w = $clog2(digit_count);
   localparam int scan_w = $clog2(digit_count * digit_cycles);
   localparam int nibble_w = 4;

   typedef logic [word_w-1:0] word_t;
   typedef logic [chunk_w-1:0] chunk_t;
   typedef logic [mem_addr_w-1:0] mem_addr_t;

   // active low, bit order g f e d c b a
   localparam logic [6:0] seg_font [16] = '{
      7'h40, 7'h79, 7'h24, 7'h30,
      7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03,
      7'h46, 7'h21, 7'h06, 7'h0e
   };

endpackage

//--- asm_loader_top.sv
`timescale 1ns/1ps

module asm_loader_top import asm_loader_pkg::*; (
   input  logic                   sys_clk,
   input  logic                   sys_rst,
   input  logic                   uart_rxd,
   input  logic [7:0]             sw,
   output logic [count_w-1:0]     led,
   output chunk_t                 display_val,
   output logic [6:0]             ss_c,
   output logic [digit_count-1:0] ss_an
);

   logic              rx_valid;
   logic [byte_w-1:0] rx_byte;

   logic      wr_stb;
   mem_addr_t wr_addr;
   word_t     wr_data;

   logic  rd_valid;
   word_t rd_data;

   uart_rx uart_rx_inst (
      .sys_clk  (sys_clk),
      .sys_rst  (sys_rst),
      .rxd      (uart_rxd),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte)
   );

   // led shows the written word count
   word_packer word_packer_inst (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .rx_valid   (rx_valid),
      .rx_byte    (rx_byte),
      .wr_stb     (wr_stb),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .word_count (led)
   );

   word_store word_store_inst (
      .sys_clk  (sys_clk),
      .sys_rst  (sys_rst),
      .wr_stb   (wr_stb),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_addr  (sw[7:2]),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

   seg_display seg_display_inst (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .chunk_sel   (sw[1:0]),
      .display_val (display_val),
      .ss_c        (ss_c),
      .ss_an       (ss_an)
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f asm_loader.f --top-module tb_asm_loader -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

if echo "$output" | grep -qF "All tests passed!"; then
   exit 0
else
   exit 1
fi

//--- seg_display.sv
`timescale 1ns/1ps

module seg_display import asm_loader_pkg::*; (
   input  logic                   sys_clk,
   input  logic                   sys_rst,
   input  logic                   rd_valid,
   input  word_t                  rd_data,
   input  logic [chunk_sel_w-1:0] chunk_sel,
   output chunk_t                 display_val,
   output logic [6:0]             ss_c,
   output logic [digit_count-1:0] ss_an
);

   word_t                  hold;
   logic [scan_w-1:0]      scan_cnt;
   logic [digit_sel_w-1:0] digit;
   logic [nibble_w-1:0]    nibble;

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         hold <= '0;
      end else if (rd_valid) begin
         hold <= rd_data;
      end
   end

   // chunk 0 is the low 32 bits
   assign display_val = hold[chunk_sel * chunk_w +: chunk_w];

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         scan_cnt <= '0;
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   // upper bits pick the digit, lower bits time it
   assign digit = scan_cnt[scan_w-1 -: digit_sel_w];

   assign ss_an = ~(digit_count'(1) << digit);

   assign nibble = display_val[digit * nibble_w +: nibble_w];
   assign ss_c = seg_font[nibble];

   a_one_anode: assert property (@(posedge sys_clk) disable iff (sys_rst)
      $onehot(~ss_an));

endmodule

//--- tb_asm_loader.sv
`timescale 1ns/1ps

module tb_asm_loader import asm_loader_pkg::*; ();

   typedef enum logic [1:0] {
      rec_word,
      rec_word_bad,
      rec_word_live,
      rec_read
   } rec_kind_t;

   typedef struct packed {
      rec_kind_t        kind;
      mem_addr_t        addr;
      logic [1:0]       chunk;
      logic [15:0][7:0] data;
      chunk_t           expected;
   } rec_t;

   localparam int num_words = 6;
   localparam int num_recs = num_words * 5;
   localparam int led_timeout = 4 * clks_per_bit;
   localparam int readback_wait = 8;

   logic                   sys_clk = 1'b0;
   logic                   sys_rst;
   logic                   uart_rxd;
   logic [7:0]             sw;
   logic [count_w-1:0]     led;
   chunk_t                 display_val;
   logic [6:0]             ss_c;
   logic [digit_count-1:0] ss_an;

   rec_t             stim_table [num_recs];
   logic [15:0][7:0] word_data [num_words];
   integer           seed = 39395;
   int               error_count = 0;
   int               check_count = 0;
   int               words_sent = 0;

   asm_loader_top asm_loader_top_inst (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .uart_rxd    (uart_rxd),
      .sw          (sw),
      .led         (led),
      .display_val (display_val),
      .ss_c        (ss_c),
      .ss_an       (ss_an)
   );

   always #10 sys_clk = ~sys_clk;

   task automatic check_value(input string name, input word_t actual, input word_t expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("error: %s is %0h, expected %0h", name, actual, expected);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge sys_clk);
   endtask

   // little-endian bytes 4c to 4c+3
   function automatic chunk_t chunk_of(input logic [15:0][7:0] b, input int c);
      return {b[4*c+3], b[4*c+2], b[4*c+1], b[4*c]};
   endfunction

   // 8N1 frame on a line that idles high
   // a low stop bit makes a framing error
   task automatic send_byte(input logic [7:0] b, input logic bad_stop);
      int i;
      uart_rxd = 1'b0;
      wait_cycles(clks_per_bit);
      for (i = 0; i < byte_w; i++) begin
         uart_rxd = b[i];
         wait_cycles(clks_per_bit);
      end
      uart_rxd = !bad_stop;
      wait_cycles(clks_per_bit);
      uart_rxd = 1'b1;
      wait_cycles(clks_per_bit);
   endtask

   task automatic wait_for_led(input logic [count_w-1:0] exp);
      int cycles;
      cycles = 0;
      while (led !== exp && cycles < led_timeout) begin
         @(negedge sys_clk);
         cycles++;
      end
      if (led !== exp) begin
         error_count++;
         $display("timeout: led did not reach %0d within %0d cycles", exp, led_timeout);
      end
   endtask

   task automatic send_word(input rec_t r);
      int k;
      for (k = 0; k < word_bytes; k++) begin
         if (r.kind == rec_word_bad && k == 8) begin
            send_byte(8'h5a, 1'b1);
         end
         // nothing may be written before the sixteenth good byte
         if (k == word_bytes - 1) begin
            wait_cycles(clks_per_bit);
            check_value("led", word_t'(led), word_t'(count_w'(words_sent % 256)));
         end
         send_byte(r.data[k], 1'b0);
      end
      words_sent++;
      wait_for_led(count_w'(words_sent % 256));
   endtask

   task automatic check_readback(input mem_addr_t addr, input logic [1:0] chunk,
                                 input chunk_t expected);
      sw = {addr, chunk};
      wait_cycles(readback_wait);
      check_value("display_val", word_t'(display_val), word_t'(expected));
   endtask

   // random reads of earlier words while the next one streams in
   task automatic readback_during_load(input int limit);
      int n;
      mem_addr_t a;
      logic [1:0] c;
      for (n = 0; n < 12; n++) begin
         a = mem_addr_t'($unsigned($random(seed)) % limit);
         c = 2'($random(seed));
         check_readback(a, c, chunk_of(word_data[a], int'(c)));
         wait_cycles(150);
      end
   endtask

   task automatic check_scan();
      int cyc;
      int i;
      int zeros;
      int pos;
      logic [digit_count-1:0] seen;
      logic [3:0] nib;
      seen = '0;
      for (cyc = 0; cyc < digit_count * digit_cycles; cyc++) begin
         @(negedge sys_clk);
         zeros = 0;
         pos = 0;
         for (i = 0; i < digit_count; i++) begin
            if (!ss_an[i]) begin
               zeros++;
               pos = i;
            end
         end
         check_value("ss_an zero count", word_t'(zeros), word_t'(1));
         nib = display_val[pos*4 +: 4];
         check_value("ss_c", word_t'(ss_c), word_t'(seg_font[nib]));
         seen[pos] = 1'b1;
      end
      check_value("ss_an digits seen", word_t'(seen), word_t'({digit_count{1'b1}}));
   endtask

   task automatic build_table();
      int w;
      int k;
      int c;
      int idx;
      for (w = 0; w < num_words; w++) begin
         for (k = 0; k < word_bytes; k++) begin
            word_data[w][k] = 8'($random(seed));
         end
         stim_table[w].kind = (w == 4) ? rec_word_bad : (w == 5) ? rec_word_live : rec_word;
         stim_table[w].addr = mem_addr_t'(w);
         stim_table[w].chunk = 2'd0;
         stim_table[w].data = word_data[w];
         stim_table[w].expected = '0;
      end
      for (w = 0; w < num_words; w++) begin
         for (c = 0; c < 4; c++) begin
            idx = num_words + 4 * w + c;
            stim_table[idx].kind = rec_read;
            stim_table[idx].addr = mem_addr_t'(w);
            stim_table[idx].chunk = 2'(c);
            stim_table[idx].data = '0;
            stim_table[idx].expected = chunk_of(word_data[w], c);
         end
      end
   endtask

   initial begin
      int i;
      int k;
      sys_rst = 1'b1;
      uart_rxd = 1'b1;
      sw = 8'h00;
      wait_cycles(2);
      sys_rst = 1'b0;
      check_value("display_val", word_t'(display_val), word_t'(0));
      check_value("led", word_t'(led), word_t'(0));

      build_table();
      for (i = 0; i < num_recs; i++) begin
         case (stim_table[i].kind)
            rec_word, rec_word_bad: send_word(stim_table[i]);
            rec_word_live: begin
               fork
                  send_word(stim_table[i]);
                  readback_during_load(int'(stim_table[i].addr));
               join
            end
            default: check_readback(stim_table[i].addr, stim_table[i].chunk,
                                    stim_table[i].expected);
         endcase
      end

      check_readback(6'd2, 2'd1, chunk_of(word_data[2], 1));
      check_scan();

      // partial word leaves the count alone
      for (k = 0; k < 5; k++) begin
         send_byte(8'($random(seed)), 1'b0);
      end
      wait_cycles(2 * clks_per_bit);
      check_value("led", word_t'(led), word_t'(count_w'(words_sent % 256)));

      $display("checks run %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx import asm_loader_pkg::*; (
   input  logic              sys_clk,
   input  logic              sys_rst,
   input  logic              rxd,
   output logic              rx_valid,
   output logic [byte_w-1:0] rx_byte
);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } rx_state_t;

   logic                 rxd_meta;
   logic                 rxd_sync;
   logic                 rxd_prev;
   rx_state_t            state;
   logic [clk_cnt_w-1:0] clk_cnt;
   logic [bit_idx_w-1:0] bit_idx;
   logic [byte_w-1:0]    rx_shift;

   // line idles high
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state <= st_idle;
         clk_cnt <= '0;
         bit_idx <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            st_idle: begin
               clk_cnt <= '0;
               bit_idx <= '0;
               if (rxd_prev && !rxd_sync) begin
                  state <= st_start;
               end
            end
            st_start: begin
               if (clk_cnt == half_bit_cnt) begin
                  clk_cnt <= '0;
                  // line back high at mid start bit means a glitch
                  state <= rxd_sync ? st_idle : st_data;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            st_data: begin
               if (clk_cnt == full_bit_cnt) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == bit_idx_w'(byte_w - 1)) begin
                     state <= st_stop;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            st_stop: begin
               if (clk_cnt == full_bit_cnt) begin
                  clk_cnt <= '0;
                  // framing error drops the byte
                  rx_valid <= rxd_sync;
                  state <= st_idle;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // lsb first
   always_ff @(posedge sys_clk) begin
      if (state == st_data && clk_cnt == full_bit_cnt) begin
         rx_shift <= {rxd_sync, rx_shift[byte_w-1:1]};
      end
      if (state == st_stop && clk_cnt == full_bit_cnt) begin
         rx_byte <= rx_shift;
      end
   end

   a_rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
      rx_valid |=> !rx_valid);

endmodule

//--- word_packer.sv
`timescale 1ns/1ps

module word_packer import asm_loader_pkg::*; (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               rx_valid,
   input  logic [byte_w-1:0]  rx_byte,
   output logic               wr_stb,
   output mem_addr_t          wr_addr,
   output word_t              wr_data,
   output logic [count_w-1:0] word_count
);

   logic [byte_idx_w-1:0] byte_idx;
   logic                  last_byte;

   assign last_byte = rx_valid && (byte_idx == byte_idx_w'(word_bytes - 1));

   // shifting right leaves byte k in bits 8k+7:8k after sixteen bytes
   always_ff @(posedge sys_clk) begin
      if (rx_valid) begin
         wr_data <= {rx_byte, wr_data[word_w-1:byte_w]};
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         byte_idx <= '0;
         wr_stb <= 1'b0;
         wr_addr <= '0;
         word_count <= '0;
      end else begin
         wr_stb <= last_byte;
         if (rx_valid) begin
            byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
         end
         // address moves on once the write has gone out
         if (wr_stb) begin
            wr_addr <= wr_addr + 1'b1;
            word_count <= word_count + 1'b1;
         end
      end
   end

   a_wr_stb_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
      wr_stb |=> !wr_stb);

endmodule

//--- word_store.sv
`timescale 1ns/1ps

module word_store import asm_loader_pkg::*; (
   input  logic      sys_clk,
   input  logic      sys_rst,
   input  logic      wr_stb,
   input  mem_addr_t wr_addr,
   input  word_t     wr_data,
   input  mem_addr_t rd_addr,
   output logic      rd_valid,
   output word_t     rd_data
);

   word_t mem [mem_words];

   // single port, a write takes the cycle
   always_ff @(posedge sys_clk) begin
      if (wr_stb) begin
         mem[wr_addr] <= wr_data;
      end else begin
         rd_data <= mem[rd_addr];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= !wr_stb;
      end
   end

   a_no_read_after_write: assert property (@(posedge sys_clk) disable iff (sys_rst)
      wr_stb |=> !rd_valid);

endmodule
